// ==== logic/engen_consts.svh ====
`ifndef ENGEN_CONSTS_SVH
`define ENGEN_CONSTS_SVH

// Channel and datapath sizing
`define ENGEN_CHANNELS 4
`define ENGEN_COUNT_WIDTH 16

// APB address and data widths
`define ENGEN_ADDR_WIDTH 8
`define ENGEN_DATA_WIDTH 32

// Register map
`define ENGEN_REG_CTRL 8'h00
`define ENGEN_REG_PERIOD 8'h04
`define ENGEN_REG_THRESH0 8'h08
`define ENGEN_REG_STATUS 8'h20

// Spacing between threshold registers
`define ENGEN_REG_STRIDE 4

// Run bit position in CTRL
`define ENGEN_CTRL_RUN_BIT 0

`endif

// ==== logic/engen_bus_pkg.sv ====
`include "engen_consts.svh"

package engen_bus_pkg;

    // Master to slave side of one APB port
    typedef struct packed {
        logic                          psel;
        logic                          penable;
        logic                          pwrite;
        logic [`ENGEN_ADDR_WIDTH-1:0]  paddr;
        logic [`ENGEN_DATA_WIDTH-1:0]  pwdata;
    } apb_req_t;

    // Slave to master side
    typedef struct packed {
        logic [`ENGEN_DATA_WIDTH-1:0]  prdata;
        logic                          pready;
        logic                          pslverr;
    } apb_rsp_t;

endpackage

// ==== logic/engen_timing_pkg.sv ====
`include "engen_consts.svh"

package engen_timing_pkg;

    // One counter or threshold value
    typedef logic [`ENGEN_COUNT_WIDTH-1:0] count_t;

    // Settings the counter needs from software
    typedef struct packed {
        logic   run;
        count_t period;
    } timing_cfg_t;

    // One bit per comparator channel
    typedef logic [`ENGEN_CHANNELS-1:0] enable_vec_t;

endpackage

// ==== logic/engen_regs.sv ====
`timescale 1ns/1ns
`include "engen_consts.svh"

module engen_regs (
    input  logic                                           clock,
    input  logic                                           reset,
    input  engen_bus_pkg::apb_req_t                        apb_req,
    output engen_bus_pkg::apb_rsp_t                        apb_rsp,
    input  engen_timing_pkg::enable_vec_t                  status,
    output engen_timing_pkg::timing_cfg_t                  timing_cfg,
    output engen_timing_pkg::count_t [`ENGEN_CHANNELS-1:0] thresholds,
    output engen_timing_pkg::enable_vec_t                  status_clear
);

    logic                         ready_q;
    logic                         access;
    logic                         done;
    logic                         write_en;
    logic                         addr_hit;
    logic                         ctrl_sel;
    logic                         period_sel;
    logic                         status_sel;
    logic [`ENGEN_CHANNELS-1:0]   thresh_sel;
    logic [`ENGEN_DATA_WIDTH-1:0] read_data;

    assign access = apb_req.psel && apb_req.penable;
    assign done = access && ready_q;
    assign write_en = done && apb_req.pwrite;

    // One wait state, ready on the second access cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= access && !ready_q;
        end
    end

    // Address decode
    always_comb begin
        ctrl_sel = apb_req.paddr == `ENGEN_REG_CTRL;
        period_sel = apb_req.paddr == `ENGEN_REG_PERIOD;
        status_sel = apb_req.paddr == `ENGEN_REG_STATUS;
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            thresh_sel[k] = apb_req.paddr ==
                `ENGEN_ADDR_WIDTH'(`ENGEN_REG_THRESH0 + `ENGEN_REG_STRIDE * k);
        end
    end

    assign addr_hit = ctrl_sel || period_sel || status_sel || (|thresh_sel);

    // Readback mux, zero for unmapped addresses
    always_comb begin
        read_data = '0;
        if (ctrl_sel) begin
            read_data[`ENGEN_CTRL_RUN_BIT] = timing_cfg.run;
        end
        if (period_sel) begin
            read_data[`ENGEN_COUNT_WIDTH-1:0] = timing_cfg.period;
        end
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            if (thresh_sel[k]) begin
                read_data[`ENGEN_COUNT_WIDTH-1:0] = thresholds[k];
            end
        end
        if (status_sel) begin
            read_data[`ENGEN_CHANNELS-1:0] = status;
        end
    end

    // Register updates on the completing cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            timing_cfg <= '0;
            thresholds <= '0;
        end else if (write_en) begin
            if (ctrl_sel) begin
                timing_cfg.run <= apb_req.pwdata[`ENGEN_CTRL_RUN_BIT];
            end
            if (period_sel) begin
                timing_cfg.period <= apb_req.pwdata[`ENGEN_COUNT_WIDTH-1:0];
            end
            for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
                if (thresh_sel[k]) begin
                    thresholds[k] <= apb_req.pwdata[`ENGEN_COUNT_WIDTH-1:0];
                end
            end
        end
    end

    // Write one to clear, applied by the collector on the same edge
    assign status_clear = (write_en && status_sel) ? apb_req.pwdata[`ENGEN_CHANNELS-1:0] : '0;

    assign apb_rsp.prdata = read_data;
    assign apb_rsp.pready = ready_q;
    assign apb_rsp.pslverr = done && !addr_hit;

    a_ready_in_access: assert property (
        @(posedge clock) disable iff (!reset)
        apb_rsp.pready |-> apb_req.psel && apb_req.penable
    );

endmodule

// ==== logic/engen_counter.sv ====
`timescale 1ns/1ns
`include "engen_consts.svh"

module engen_counter (
    input  logic                          clock,
    input  logic                          reset,
    input  engen_timing_pkg::timing_cfg_t timing_cfg,
    input  logic                          gen_enable,
    output engen_timing_pkg::count_t      count
);

    logic                     running;
    engen_timing_pkg::count_t last_count;

    // Software run bit or external trigger, never with a zero period
    assign running = (timing_cfg.run || gen_enable) && (timing_cfg.period != '0);
    assign last_count = timing_cfg.period - 1'b1;

    always_ff @(posedge clock) begin
        if (!reset) begin
            count <= '0;
        end else if (!running) begin
            count <= '0;
        end else if (count >= last_count) begin
            // Also catches a period shrunk below the current count
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    a_count_in_range: assert property (
        @(posedge clock) disable iff (!reset)
        (timing_cfg.period != '0) ##1 $stable(timing_cfg.period)
            |-> count < timing_cfg.period
    );

endmodule

// ==== logic/engen_comparator.sv ====
`timescale 1ns/1ns
`include "engen_consts.svh"

module engen_comparator (
    input  logic                     clock,
    input  logic                     reset,
    input  engen_timing_pkg::count_t threshold,
    input  engen_timing_pkg::count_t count,
    output logic                     pulse
);

    logic match;

    assign match = count == threshold;

    // One cycle latency from match to pulse
    always_ff @(posedge clock) begin
        if (!reset) begin
            pulse <= 1'b0;
        end else begin
            pulse <= match;
        end
    end

    // Back to back pulses only when the stopped counter sits on a zero threshold
    a_single_pulse: assert property (
        @(posedge clock) disable iff (!reset)
        pulse |=> !pulse || ($past(threshold) == '0 && $past(count) == '0)
    );

endmodule

// ==== logic/engen_collector.sv ====
`timescale 1ns/1ns
`include "engen_consts.svh"

module engen_collector (
    input  logic                          clock,
    input  logic                          reset,
    input  engen_timing_pkg::enable_vec_t pulse,
    input  engen_timing_pkg::enable_vec_t status_clear,
    output engen_timing_pkg::enable_vec_t enable_out,
    output engen_timing_pkg::enable_vec_t status
);

    engen_timing_pkg::enable_vec_t status_next;

    // A new pulse wins over a clear in the same cycle
    assign status_next = (status & ~status_clear) | pulse;

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable_out <= '0;
        end else begin
            enable_out <= pulse;
        end
    end

    // Sticky fired bits, set alongside enable_out
    always_ff @(posedge clock) begin
        if (!reset) begin
            status <= '0;
        end else begin
            status <= status_next;
        end
    end

endmodule

// ==== logic/enable_generator.sv ====
`timescale 1ns/1ns
`include "engen_consts.svh"

module enable_generator (
    input  logic                          clock,
    input  logic                          reset,
    input  engen_bus_pkg::apb_req_t       apb_req,
    output engen_bus_pkg::apb_rsp_t       apb_rsp,
    input  logic                          gen_enable,
    output engen_timing_pkg::enable_vec_t enable_out,
    output engen_timing_pkg::enable_vec_t status
);

    engen_timing_pkg::timing_cfg_t                  timing_cfg;
    engen_timing_pkg::count_t [`ENGEN_CHANNELS-1:0] thresholds;
    engen_timing_pkg::count_t                       count;
    engen_timing_pkg::enable_vec_t                  pulse;
    engen_timing_pkg::enable_vec_t                  status_clear;

    engen_regs u_regs (
        .clock        (clock),
        .reset        (reset),
        .apb_req      (apb_req),
        .apb_rsp      (apb_rsp),
        .status       (status),
        .timing_cfg   (timing_cfg),
        .thresholds   (thresholds),
        .status_clear (status_clear)
    );

    engen_counter u_counter (
        .clock      (clock),
        .reset      (reset),
        .timing_cfg (timing_cfg),
        .gen_enable (gen_enable),
        .count      (count)
    );

    // One comparator per channel, all watching the shared count
    for (genvar k = 0; k < `ENGEN_CHANNELS; k++) begin : g_channel
        engen_comparator u_comparator (
            .clock     (clock),
            .reset     (reset),
            .threshold (thresholds[k]),
            .count     (count),
            .pulse     (pulse[k])
        );
    end

    engen_collector u_collector (
        .clock        (clock),
        .reset        (reset),
        .pulse        (pulse),
        .status_clear (status_clear),
        .enable_out   (enable_out),
        .status       (status)
    );

endmodule

// ==== tb/enable_generator_tb.sv ====
`timescale 1ns/1ns
`include "engen_consts.svh"

module enable_generator_tb;

    logic                          clock;
    logic                          reset;
    logic                          gen_enable;
    engen_bus_pkg::apb_req_t       apb_req;
    engen_bus_pkg::apb_rsp_t       apb_rsp;
    engen_timing_pkg::enable_vec_t enable_out;
    engen_timing_pkg::enable_vec_t status;

    logic [31:0] lcg_state = 32'h1ae1_a374;
    logic [31:0] rdata;
    logic        err;
    int          period;
    int          thresh[`ENGEN_CHANNELS];
    int          first_high[`ENGEN_CHANNELS];
    int          high_count[`ENGEN_CHANNELS];
    int          error_count = 0;
    int          errors_at_start = 0;
    int          test_count = 0;
    int          failed_count = 0;

    enable_generator u_enable_generator (
        .clock      (clock),
        .reset      (reset),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .gen_enable (gen_enable),
        .enable_out (enable_out),
        .status     (status)
    );

    always #4 clock = !clock;

    // Single wait state, pready low on the first access cycle and high on the second
    a_one_wait_state: assert property (
        @(posedge clock) disable iff (!reset)
        (apb_req.psel && apb_req.penable)
            |-> (apb_rsp.pready == $past(apb_req.psel && apb_req.penable))
    ) else begin
        $display("APB pready did not come on the second access cycle");
        error_count++;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed", name);
            failed_count++;
        end
        errors_at_start = error_count;
    endtask

    // Setup cycle, then access cycles until pready
    task automatic apb_transfer(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata);
        int waited;
        @(posedge clock);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        @(posedge clock);
        apb_req.penable <= 1'b1;
        waited = 0;
        @(negedge clock);
        while (!apb_rsp.pready && waited < 16) begin
            @(negedge clock);
            waited++;
        end
        if (!apb_rsp.pready) begin
            $display("APB transfer to address %0h never saw pready", addr);
            error_count++;
        end
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clock);
        apb_req <= '0;
    endtask

    task automatic reg_write(input logic [7:0] addr, input logic [31:0] wdata);
        apb_transfer(1'b1, addr, wdata);
    endtask

    task automatic reg_read_check(input string name, input logic [7:0] addr,
                                  input logic [31:0] expected);
        apb_transfer(1'b0, addr, 32'h0);
        check_value(name, expected, rdata);
        check_value(name, 0, err);
    endtask

    // Record every enable_out high; successive highs must sit one period apart
    task automatic watch_outputs(input string name, input int cycles);
        int last_high[`ENGEN_CHANNELS];
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            first_high[k] = -1;
            last_high[k] = -1;
            high_count[k] = 0;
        end
        for (int c = 0; c < cycles; c++) begin
            @(negedge clock);
            for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
                if (enable_out[k]) begin
                    if (last_high[k] >= 0) begin
                        check_value(name, period, c - last_high[k]);
                    end else begin
                        first_high[k] = c;
                    end
                    last_high[k] = c;
                    high_count[k]++;
                end
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        gen_enable = 1'b0;
        apb_req = '0;
        repeat (4) @(posedge clock);
        reset <= 1'b1;

        period = 8 + int'(next_random() % 33);
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            thresh[k] = 1 + int'(next_random() % (period - 1));
        end

        reg_write(`ENGEN_REG_PERIOD, period);
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            reg_write(`ENGEN_REG_THRESH0 + 4 * k, thresh[k]);
        end
        reg_read_check("register readback", `ENGEN_REG_PERIOD, period);
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            reg_read_check("register readback", `ENGEN_REG_THRESH0 + 4 * k, thresh[k]);
        end
        reg_write(`ENGEN_REG_CTRL, 32'h1);
        reg_read_check("register readback", `ENGEN_REG_CTRL, 32'h1);
        reg_write(`ENGEN_REG_CTRL, 32'h0);
        reg_read_check("register readback", `ENGEN_REG_CTRL, 32'h0);
        apb_transfer(1'b0, 8'h40, 32'h0);
        check_value("register readback", 0, rdata);
        check_value("register readback", 1, err);
        finish_test("register readback");

        reg_write(`ENGEN_REG_CTRL, 32'h1);
        watch_outputs("pulse period", 4 * period);
        // Count is 0 in the first watched cycle, match to enable_out takes two cycles
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            check_value("pulse period", thresh[k] + 2, first_high[k]);
            check_value("pulse period", 1 + (4 * period - 3 - thresh[k]) / period,
                        high_count[k]);
        end
        finish_test("pulse period");

        // Phase of every channel against channel 0
        for (int k = 1; k < `ENGEN_CHANNELS; k++) begin
            check_value("channel phase", ((thresh[k] - thresh[0]) % period + period) % period,
                        ((first_high[k] - first_high[0]) % period + period) % period);
        end
        finish_test("channel phase");

        reg_write(`ENGEN_REG_CTRL, 32'h0);
        repeat (3) @(posedge clock);
        watch_outputs("stop and trigger", 3 * period);
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            check_value("stop and trigger", 0, high_count[k]);
        end
        @(posedge clock);
        gen_enable <= 1'b1;
        watch_outputs("stop and trigger", 2 * period + 4);
        for (int k = 0; k < `ENGEN_CHANNELS; k++) begin
            check_value("stop and trigger", 1, 32'(first_high[k] >= 0));
        end
        @(posedge clock);
        gen_enable <= 1'b0;
        repeat (3) @(posedge clock);
        finish_test("stop and trigger");

        thresh[3] = period + int'(next_random() % 16);
        reg_write(`ENGEN_REG_THRESH0 + 12, thresh[3]);
        reg_write(`ENGEN_REG_STATUS, 32'hf);
        @(negedge clock);
        check_value("threshold range", 0, status);
        reg_write(`ENGEN_REG_CTRL, 32'h1);
        watch_outputs("threshold range", 3 * period);
        check_value("threshold range", 0, high_count[3]);
        check_value("threshold range", 0, status[3]);
        reg_write(`ENGEN_REG_CTRL, 32'h0);
        repeat (3) @(posedge clock);
        finish_test("threshold range");

        // Channels 0 to 2 fired during the last run, channel 3 never did
        reg_read_check("sticky status", `ENGEN_REG_STATUS, 32'h7);
        @(negedge clock);
        check_value("sticky status", 4'h7, status);
        reg_write(`ENGEN_REG_STATUS, 32'h5);
        reg_read_check("sticky status", `ENGEN_REG_STATUS, 32'h2);
        @(negedge clock);
        check_value("sticky status", 4'h2, status);
        reg_write(`ENGEN_REG_STATUS, 32'h2);
        reg_read_check("sticky status", `ENGEN_REG_STATUS, 32'h0);
        @(negedge clock);
        check_value("sticky status", 4'h0, status);
        finish_test("sticky status");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+logic
logic/engen_bus_pkg.sv
logic/engen_timing_pkg.sv
logic/engen_regs.sv
logic/engen_counter.sv
logic/engen_comparator.sv
logic/engen_collector.sv
logic/enable_generator.sv
tb/enable_generator_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the enable generator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module enable_generator_tb -o enable_generator_sim \
    && ./obj_dir/enable_generator_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "simulation build or run failed"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; }
echo "PASS"
exit 0
